// ==== Makefile ====
TOP := tb_dispatcher

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f list.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f list.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) > sim.log 2>&1 || true
	cat sim.log
	@if grep -q "TEST FAIL" sim.log; then echo "Simulation reported a failure"; exit 1; fi
	@if ! grep -q "TEST PASS" sim.log; then echo "Simulation ended without a result"; exit 1; fi

clean:
	rm -rf obj_dir sim.log

// ==== list.f ====
+incdir+source
source/disp_pkg.sv
source/disp_cmd_if.sv
source/dispatch_ctrl.sv
source/batch_sequencer.sv
source/column_map.sv
source/line_copier.sv
source/dispatcher_top.sv
tb/dispatcher_sva.sv
tb/tb_dispatcher.sv

// ==== source/batch_sequencer.sv ====
module batch_sequencer (
    input  logic                    i_clk,
    input  logic                    i_reset_n,
    disp_cmd_if.seq                 cmd,
    // Enabled column count from the column map
    input  disp_pkg::batch_cnt_t    i_col_count,
    output disp_pkg::col_idx_t      o_rr_idx,
    // Per-line copy request
    output logic                    o_line_valid,
    output disp_pkg::src_addr_t     o_src_addr,
    output disp_pkg::tile_addr_t    o_dst_addr
);

    logic                   busy_q;
    disp_pkg::line_cnt_t    within_q;
    disp_pkg::batch_cnt_t   batch_q;
    disp_pkg::col_idx_t     rr_q;
    disp_pkg::src_addr_t    src_ptr_q;
    disp_pkg::tile_addr_t   dst_ptr_q;

    // Current values, start selects the initial load
    logic                   active;
    disp_pkg::line_cnt_t    within_cur;
    disp_pkg::batch_cnt_t   batch_cur;
    disp_pkg::col_idx_t     rr_cur;
    disp_pkg::src_addr_t    src_cur;
    disp_pkg::tile_addr_t   dst_cur;
    disp_pkg::col_idx_t     rr_start;
    logic                   batch_end;
    logic                   last_batch;
    logic                   rr_wrap;

    // ==============================
    // Initial load and current view
    // ==============================
    always_comb begin
        // Start column reduced modulo enabled count
        if (i_col_count == '0) begin
            rr_start = '0;
        end else begin
            rr_start = disp_pkg::col_idx_t'(disp_pkg::batch_cnt_t'(cmd.col_start) % i_col_count);
        end
    end

    assign active     = cmd.start || busy_q;
    assign within_cur = cmd.start ? '0 : within_q;
    assign batch_cur  = cmd.start ? '0 : batch_q;
    assign rr_cur     = cmd.start ? rr_start : rr_q;
    assign src_cur    = cmd.start ? '0 : src_ptr_q;
    assign dst_cur    = cmd.start ? cmd.tile_base : dst_ptr_q;

    assign batch_end  = (within_cur == cmd.batch_lines - 10'd1);
    assign last_batch = (batch_cur == cmd.total_batches - 8'd1);
    // Round robin wraps back to index zero
    assign rr_wrap    = (disp_pkg::batch_cnt_t'(rr_cur) + 8'd1) == i_col_count;

    // ==============================
    // Counter update, once per busy cycle
    // ==============================
    always_ff @(posedge i_clk) begin
        if (!i_reset_n) begin
            busy_q    <= 1'b0;
            within_q  <= '0;
            batch_q   <= '0;
            rr_q      <= '0;
            src_ptr_q <= '0;
            dst_ptr_q <= '0;
        end else if (active) begin
            busy_q    <= !cmd.last_line;
            within_q  <= within_cur + 10'd1;
            batch_q   <= batch_cur;
            rr_q      <= rr_cur;
            src_ptr_q <= src_cur;
            dst_ptr_q <= dst_cur;
            if (batch_end) begin
                within_q  <= '0;
                batch_q   <= batch_cur + 8'd1;
                rr_q      <= rr_wrap ? '0 : rr_cur + 3'd1;
                src_ptr_q <= src_cur + disp_pkg::src_addr_t'(cmd.batch_lines);
                // Broadcast steps every batch, distribute only on wrap
                if (cmd.mode == disp_pkg::BROADCAST || rr_wrap) begin
                    dst_ptr_q <= dst_cur + disp_pkg::tile_addr_t'(cmd.batch_lines);
                end
            end
        end
    end

    // Final copy cycle of the final batch
    assign cmd.last_line = active && batch_end && last_batch;
    assign cmd.busy      = active;

    assign o_line_valid  = active;
    assign o_rr_idx      = rr_cur;
    // Pointer plus offset, wraps at the buffer depth
    assign o_src_addr    = src_cur + disp_pkg::src_addr_t'(within_cur);
    assign o_dst_addr    = dst_cur + disp_pkg::tile_addr_t'(within_cur);

endmodule

// ==== source/column_map.sv ====
module column_map (
    disp_cmd_if.cmap                cmd,
    input  disp_pkg::col_idx_t      i_rr_idx,
    output disp_pkg::batch_cnt_t    o_col_count,
    output disp_pkg::col_mask_t     o_col_mask
);

    disp_pkg::batch_cnt_t   ones;
    disp_pkg::batch_cnt_t   rank;
    disp_pkg::col_mask_t    pick;

    // Popcount of the enabled columns
    always_comb begin
        ones = '0;
        for (int i = 0; i < $bits(disp_pkg::col_mask_t); i++) begin
            ones = ones + disp_pkg::batch_cnt_t'(cmd.col_en[i]);
        end
    end

    // ==============================
    // Round-robin index to column
    // ==============================
    // Rank counts set bits from bit zero, enabled columns may be sparse
    always_comb begin
        rank = '0;
        pick = '0;
        for (int i = 0; i < $bits(disp_pkg::col_mask_t); i++) begin
            if (cmd.col_en[i]) begin
                if (rank == disp_pkg::batch_cnt_t'(i_rr_idx)) begin
                    pick[i] = 1'b1;
                end
                rank = rank + 8'd1;
            end
        end
    end

    assign o_col_count = ones;
    // Broadcast writes every enabled column at once
    assign o_col_mask  = (cmd.mode == disp_pkg::BROADCAST) ? cmd.col_en : pick;

endmodule

// ==== source/disp_cfg.svh ====
`ifndef DISP_CFG_SVH
`define DISP_CFG_SVH

// ==============================
// Data widths
// ==============================
`define DISP_MAN_W          32
`define DISP_EXP_W          8

// ==============================
// Buffer geometry
// ==============================
// Source buffer, 512 lines per side
`define DISP_SRC_AW         9
`define DISP_TILE_AW        9

// Tile columns and index width
`define DISP_NUM_COLS       8
`define DISP_COL_IDX_W      3

// Lines carried by one vector
`define DISP_LINES_PER_VEC  4

`endif

// ==== source/disp_cmd_if.sv ====
`include "disp_cfg.svh"

interface disp_cmd_if;

    // Captured command, held for the whole copy
    logic                   start;
    logic                   side_right;
    disp_pkg::disp_mode_e   mode;
    disp_pkg::col_mask_t    col_en;
    disp_pkg::col_idx_t     col_start;
    disp_pkg::tile_addr_t   tile_base;
    // Derived batch figures
    disp_pkg::line_cnt_t    batch_lines;
    disp_pkg::batch_cnt_t   total_batches;

    // Sequencing events back from the counters
    logic                   last_line;
    logic                   busy;

    modport ctrl (
        output start, side_right, mode, col_en, col_start, tile_base,
        output batch_lines, total_batches,
        input  last_line, busy
    );

    modport seq (
        input  start, mode, col_start, tile_base, batch_lines, total_batches,
        output last_line, busy
    );

    modport cmap (
        input  col_en, col_start, mode
    );

endinterface

// ==== source/disp_pkg.sv ====
`include "disp_cfg.svh"

package disp_pkg;

    // Handshake FSM states
    typedef enum logic [1:0] {
        IDLE         = 2'd0,
        BUSY         = 2'd1,
        DONE         = 2'd2,
        WAIT_REQ_LOW = 2'd3
    } disp_state_e;

    // Dispatch opcode
    typedef enum logic {
        DISTRIBUTE = 1'b0,
        BROADCAST  = 1'b1
    } disp_mode_e;

    // Buffer addresses
    typedef logic [`DISP_SRC_AW-1:0]    src_addr_t;
    typedef logic [`DISP_TILE_AW-1:0]   tile_addr_t;

    // One bit per tile column
    typedef logic [`DISP_NUM_COLS-1:0]  col_mask_t;
    typedef logic [`DISP_COL_IDX_W-1:0] col_idx_t;

    // Batch, vector and line counts
    typedef logic [7:0]                 batch_cnt_t;
    typedef logic [9:0]                 line_cnt_t;

endpackage

// ==== source/dispatch_ctrl.sv ====
`include "disp_cfg.svh"

module dispatch_ctrl (
    input  logic                    i_clk,
    input  logic                    i_reset_n,
    // Four-phase command handshake
    input  logic                    i_cmd_req,
    output logic                    o_cmd_ack,
    // Command fields, stable while req is high
    input  disp_pkg::tile_addr_t    i_cmd_tile_addr,
    input  disp_pkg::batch_cnt_t    i_cmd_nv_cnt,
    input  disp_pkg::batch_cnt_t    i_cmd_vec_size,
    input  disp_pkg::col_mask_t     i_cmd_col_en,
    input  disp_pkg::col_idx_t      i_cmd_col_start,
    input  logic                    i_cmd_right,
    input  logic                    i_cmd_broadcast,
    disp_cmd_if.ctrl                cmd
);

    disp_pkg::disp_state_e state_q;
    disp_pkg::disp_state_e state_d;
    logic                  ack_q;
    logic                  take_cmd;

    // ==============================
    // Handshake FSM
    // ==============================
    always_comb begin
        state_d = state_q;
        case (state_q)
            disp_pkg::IDLE: begin
                // Req sampled high, counters must be idle
                if (i_cmd_req && !cmd.busy) begin
                    state_d = disp_pkg::BUSY;
                end
            end
            disp_pkg::BUSY: begin
                // One line per cycle until the final copy
                if (cmd.last_line) begin
                    state_d = disp_pkg::DONE;
                end
            end
            disp_pkg::DONE: begin
                state_d = disp_pkg::WAIT_REQ_LOW;
            end
            disp_pkg::WAIT_REQ_LOW: begin
                // Host must release req before the next command
                if (!i_cmd_req) begin
                    state_d = disp_pkg::IDLE;
                end
            end
            default: begin
                state_d = disp_pkg::IDLE;
            end
        endcase
    end

    assign take_cmd = (state_q == disp_pkg::IDLE) && (state_d == disp_pkg::BUSY);

    always_ff @(posedge i_clk) begin
        if (!i_reset_n) begin
            state_q   <= disp_pkg::IDLE;
            ack_q     <= 1'b0;
            cmd.start <= 1'b0;
        end else begin
            state_q   <= state_d;
            // Ack set leaving DONE, held through WAIT_REQ_LOW
            ack_q     <= (state_d == disp_pkg::WAIT_REQ_LOW);
            // Start marks the first BUSY cycle
            cmd.start <= take_cmd;
        end
    end

    // ==============================
    // Command capture
    // ==============================
    always_ff @(posedge i_clk) begin
        if (take_cmd) begin
            cmd.side_right    <= i_cmd_right;
            cmd.mode          <= i_cmd_broadcast ? disp_pkg::BROADCAST : disp_pkg::DISTRIBUTE;
            cmd.col_en        <= i_cmd_col_en;
            cmd.col_start     <= i_cmd_col_start;
            cmd.tile_base     <= i_cmd_tile_addr;
            // Lines per batch, vector size times four
            cmd.batch_lines   <= disp_pkg::line_cnt_t'(disp_pkg::line_cnt_t'(i_cmd_vec_size)
                                 * `DISP_LINES_PER_VEC);
            // Vector size divides NV count by contract
            cmd.total_batches <= i_cmd_nv_cnt / i_cmd_vec_size;
        end
    end

    assign o_cmd_ack = ack_q;

endmodule

// ==== source/dispatcher_top.sv ====
`include "disp_cfg.svh"

module dispatcher_top (
    input  logic                        i_clk,
    input  logic                        i_reset_n,
    // Command handshake and fields
    input  logic                        i_cmd_req,
    output logic                        o_cmd_ack,
    input  disp_pkg::tile_addr_t        i_cmd_tile_addr,
    input  disp_pkg::batch_cnt_t        i_cmd_nv_cnt,
    input  disp_pkg::batch_cnt_t        i_cmd_vec_size,
    input  disp_pkg::col_mask_t         i_cmd_col_en,
    input  disp_pkg::col_idx_t          i_cmd_col_start,
    input  logic                        i_cmd_right,
    input  logic                        i_cmd_broadcast,
    // Source buffer reads
    output logic                        o_src_left_rd_en,
    output logic                        o_src_right_rd_en,
    output disp_pkg::src_addr_t         o_src_left_rd_addr,
    output disp_pkg::src_addr_t         o_src_right_rd_addr,
    input  logic [`DISP_MAN_W-1:0]      i_src_left_man,
    input  logic [`DISP_MAN_W-1:0]      i_src_right_man,
    input  logic [`DISP_EXP_W-1:0]      i_src_left_exp,
    input  logic [`DISP_EXP_W-1:0]      i_src_right_exp,
    // Tile buffer writes
    output logic                        o_tile_left_wr_en,
    output logic                        o_tile_right_wr_en,
    output disp_pkg::tile_addr_t        o_tile_wr_addr,
    output logic [`DISP_MAN_W-1:0]      o_tile_man,
    output logic [`DISP_EXP_W-1:0]      o_tile_exp,
    output disp_pkg::col_mask_t         o_tile_col_wr_en
);

    // Sequencer to copier
    logic                   line_valid;
    disp_pkg::src_addr_t    src_addr;
    disp_pkg::tile_addr_t   dst_addr;
    // Between sequencer and column map
    disp_pkg::batch_cnt_t   col_count;
    disp_pkg::col_idx_t     rr_idx;
    disp_pkg::col_mask_t    col_mask;

    disp_cmd_if cmd_if ();

    dispatch_ctrl u_ctrl (
        .i_clk           (i_clk),
        .i_reset_n       (i_reset_n),
        .i_cmd_req       (i_cmd_req),
        .o_cmd_ack       (o_cmd_ack),
        .i_cmd_tile_addr (i_cmd_tile_addr),
        .i_cmd_nv_cnt    (i_cmd_nv_cnt),
        .i_cmd_vec_size  (i_cmd_vec_size),
        .i_cmd_col_en    (i_cmd_col_en),
        .i_cmd_col_start (i_cmd_col_start),
        .i_cmd_right     (i_cmd_right),
        .i_cmd_broadcast (i_cmd_broadcast),
        .cmd             (cmd_if.ctrl)
    );

    batch_sequencer u_seq (
        .i_clk        (i_clk),
        .i_reset_n    (i_reset_n),
        .cmd          (cmd_if.seq),
        .i_col_count  (col_count),
        .o_rr_idx     (rr_idx),
        .o_line_valid (line_valid),
        .o_src_addr   (src_addr),
        .o_dst_addr   (dst_addr)
    );

    column_map u_cmap (
        .cmd         (cmd_if.cmap),
        .i_rr_idx    (rr_idx),
        .o_col_count (col_count),
        .o_col_mask  (col_mask)
    );

    line_copier u_copy (
        .i_line_valid        (line_valid),
        .i_side_right        (cmd_if.side_right),
        .i_src_addr          (src_addr),
        .i_dst_addr          (dst_addr),
        .i_col_mask          (col_mask),
        .o_src_left_rd_en    (o_src_left_rd_en),
        .o_src_right_rd_en   (o_src_right_rd_en),
        .o_src_left_rd_addr  (o_src_left_rd_addr),
        .o_src_right_rd_addr (o_src_right_rd_addr),
        .i_src_left_man      (i_src_left_man),
        .i_src_right_man     (i_src_right_man),
        .i_src_left_exp      (i_src_left_exp),
        .i_src_right_exp     (i_src_right_exp),
        .o_tile_left_wr_en   (o_tile_left_wr_en),
        .o_tile_right_wr_en  (o_tile_right_wr_en),
        .o_tile_wr_addr      (o_tile_wr_addr),
        .o_tile_man          (o_tile_man),
        .o_tile_exp          (o_tile_exp),
        .o_tile_col_wr_en    (o_tile_col_wr_en)
    );

endmodule

// ==== source/line_copier.sv ====
`include "disp_cfg.svh"

module line_copier (
    input  logic                        i_line_valid,
    input  logic                        i_side_right,
    input  disp_pkg::src_addr_t         i_src_addr,
    input  disp_pkg::tile_addr_t        i_dst_addr,
    input  disp_pkg::col_mask_t         i_col_mask,
    // Source buffer read side
    output logic                        o_src_left_rd_en,
    output logic                        o_src_right_rd_en,
    output disp_pkg::src_addr_t         o_src_left_rd_addr,
    output disp_pkg::src_addr_t         o_src_right_rd_addr,
    input  logic [`DISP_MAN_W-1:0]      i_src_left_man,
    input  logic [`DISP_MAN_W-1:0]      i_src_right_man,
    input  logic [`DISP_EXP_W-1:0]      i_src_left_exp,
    input  logic [`DISP_EXP_W-1:0]      i_src_right_exp,
    // Tile buffer write side
    output logic                        o_tile_left_wr_en,
    output logic                        o_tile_right_wr_en,
    output disp_pkg::tile_addr_t        o_tile_wr_addr,
    output logic [`DISP_MAN_W-1:0]      o_tile_man,
    output logic [`DISP_EXP_W-1:0]      o_tile_exp,
    output disp_pkg::col_mask_t         o_tile_col_wr_en
);

    logic left_sel;
    logic right_sel;

    // Only the selected side is touched
    assign left_sel  = i_line_valid && !i_side_right;
    assign right_sel = i_line_valid && i_side_right;

    // ==============================
    // Source reads
    // ==============================
    assign o_src_left_rd_en    = left_sel;
    assign o_src_right_rd_en   = right_sel;
    // Idle side address parked at zero
    assign o_src_left_rd_addr  = left_sel ? i_src_addr : '0;
    assign o_src_right_rd_addr = right_sel ? i_src_addr : '0;

    // ==============================
    // Tile writes, same cycle as read
    // ==============================
    assign o_tile_left_wr_en   = left_sel;
    assign o_tile_right_wr_en  = right_sel;
    assign o_tile_wr_addr      = i_dst_addr;
    assign o_tile_man          = i_side_right ? i_src_right_man : i_src_left_man;
    assign o_tile_exp          = i_side_right ? i_src_right_exp : i_src_left_exp;
    // Column enables only during a copy
    assign o_tile_col_wr_en    = i_line_valid ? i_col_mask : '0;

endmodule

// ==== tb/dispatcher_sva.sv ====
module dispatcher_sva (
    input  logic                    i_clk,
    input  logic                    i_reset_n,
    input  logic                    i_req,
    input  logic                    i_ack,
    input  logic                    i_left_wr_en,
    input  logic                    i_right_wr_en,
    input  disp_pkg::col_mask_t     i_col_wr_en
);

    // ==============================
    // Tile write side
    // ==============================
    // Writes only while a command is held and not yet acknowledged
    a_write_in_cmd: assert property (@(posedge i_clk) disable iff (!i_reset_n)
        (i_left_wr_en || i_right_wr_en) |-> (i_req && !i_ack))
        else $error("tile write outside an open command");

    // Every write lands in at least one column
    a_mask_on_write: assert property (@(posedge i_clk) disable iff (!i_reset_n)
        (i_left_wr_en || i_right_wr_en) |-> (i_col_wr_en != '0))
        else $error("tile write with an empty column mask");

    // ==============================
    // Handshake
    // ==============================
    a_ack_needs_req: assert property (@(posedge i_clk) disable iff (!i_reset_n)
        $rose(i_ack) |-> i_req)
        else $error("ack rose while req was low");

endmodule

// Watches the top-level handshake and tile write ports
bind dispatcher_top dispatcher_sva u_sva (
    .i_clk         (i_clk),
    .i_reset_n     (i_reset_n),
    .i_req         (i_cmd_req),
    .i_ack         (o_cmd_ack),
    .i_left_wr_en  (o_tile_left_wr_en),
    .i_right_wr_en (o_tile_right_wr_en),
    .i_col_wr_en   (o_tile_col_wr_en)
);

// ==== tb/tb_dispatcher.sv ====
`include "disp_cfg.svh"

module tb_dispatcher;

    localparam int num_dir    = 4;
    localparam int num_cmds   = 24;
    localparam int src_depth  = 1 << `DISP_SRC_AW;
    localparam int tile_depth = 1 << `DISP_TILE_AW;

    // DUT ports, names match dispatcher_top
    logic                       i_clk;
    logic                       i_reset_n;
    logic                       i_cmd_req;
    logic                       o_cmd_ack;
    disp_pkg::tile_addr_t       i_cmd_tile_addr;
    disp_pkg::batch_cnt_t       i_cmd_nv_cnt;
    disp_pkg::batch_cnt_t       i_cmd_vec_size;
    disp_pkg::col_mask_t        i_cmd_col_en;
    disp_pkg::col_idx_t         i_cmd_col_start;
    logic                       i_cmd_right;
    logic                       i_cmd_broadcast;
    logic                       o_src_left_rd_en;
    logic                       o_src_right_rd_en;
    disp_pkg::src_addr_t        o_src_left_rd_addr;
    disp_pkg::src_addr_t        o_src_right_rd_addr;
    logic [`DISP_MAN_W-1:0]     i_src_left_man;
    logic [`DISP_MAN_W-1:0]     i_src_right_man;
    logic [`DISP_EXP_W-1:0]     i_src_left_exp;
    logic [`DISP_EXP_W-1:0]     i_src_right_exp;
    logic                       o_tile_left_wr_en;
    logic                       o_tile_right_wr_en;
    disp_pkg::tile_addr_t       o_tile_wr_addr;
    logic [`DISP_MAN_W-1:0]     o_tile_man;
    logic [`DISP_EXP_W-1:0]     o_tile_exp;
    disp_pkg::col_mask_t        o_tile_col_wr_en;

    // Command list, directed entries first
    disp_pkg::tile_addr_t       tile_q  [num_cmds];
    disp_pkg::batch_cnt_t       nv_q    [num_cmds];
    disp_pkg::batch_cnt_t       vs_q    [num_cmds];
    disp_pkg::col_mask_t        en_q    [num_cmds];
    disp_pkg::col_idx_t         start_q [num_cmds];
    logic                       right_q [num_cmds];
    logic                       bcast_q [num_cmds];

    int                         cur_cmd;
    int                         exp_lines;
    int                         wr_cnt;
    int                         cycle_cnt;
    int                         cycle_limit;
    logic [15:0]                lfsr_q;

    dispatcher_top dut0 (.*);

    initial begin
        i_clk = 1'b0;
        forever #2 i_clk = ~i_clk;
    end

    // ==============================
    // Source buffer model
    // ==============================
    // Side tag in the top byte, full address in the low bits
    function automatic logic [31:0] src_man(input disp_pkg::src_addr_t addr, input logic side);
        src_man = {side ? 8'hC3 : 8'h3C, 7'h00, addr, addr[7:0] ^ 8'h5A};
    endfunction

    function automatic logic [7:0] src_exp(input disp_pkg::src_addr_t addr, input logic side);
        src_exp = addr[7:0] ^ {addr[8], side, 6'h15};
    endfunction

    // Combinational read, as the real buffer
    assign i_src_left_man  = src_man(o_src_left_rd_addr, 1'b0);
    assign i_src_right_man = src_man(o_src_right_rd_addr, 1'b1);
    assign i_src_left_exp  = src_exp(o_src_left_rd_addr, 1'b0);
    assign i_src_right_exp = src_exp(o_src_right_rd_addr, 1'b1);

    // ==============================
    // Reference model
    // ==============================
    // Expected line n of the current command
    function automatic void ref_line(input int n, output disp_pkg::src_addr_t exp_src,
                                     output disp_pkg::tile_addr_t exp_dst,
                                     output disp_pkg::col_mask_t exp_mask);
        int lines;
        int batch;
        int off;
        int count;
        int idx;
        int seen;
        lines = int'(vs_q[cur_cmd]) * `DISP_LINES_PER_VEC;
        batch = n / lines;
        off   = n % lines;
        count = 0;
        for (int i = 0; i < `DISP_NUM_COLS; i++) begin
            count = count + int'(en_q[cur_cmd][i]);
        end
        exp_src = disp_pkg::src_addr_t'((batch * lines + off) % src_depth);
        if (bcast_q[cur_cmd]) begin
            exp_mask = en_q[cur_cmd];
            exp_dst  = disp_pkg::tile_addr_t'((int'(tile_q[cur_cmd]) + batch * lines + off)
                       % tile_depth);
        end else begin
            // Round robin from start column mod count, dest steps once per wrap
            idx      = (int'(start_q[cur_cmd]) % count + batch) % count;
            exp_dst  = disp_pkg::tile_addr_t'((int'(tile_q[cur_cmd])
                       + ((int'(start_q[cur_cmd]) % count + batch) / count) * lines + off)
                       % tile_depth);
            exp_mask = '0;
            seen     = 0;
            for (int i = 0; i < `DISP_NUM_COLS; i++) begin
                if (en_q[cur_cmd][i]) begin
                    if (seen == idx) begin
                        exp_mask[i] = 1'b1;
                    end
                    seen = seen + 1;
                end
            end
        end
    endfunction

    // ==============================
    // Checking helpers
    // ==============================
    task automatic abort_run(input string why);
        $display("ERROR at %0t: %s", $time, why);
        $display("TEST FAIL");
        $fatal(1, "run stopped");
    endtask

    task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s got 0x%0h expected 0x%0h", $time, name, got, exp);
            abort_run("value check failed");
        end
    endtask

    // Galois LFSR, one step per bit taken
    function automatic int draw_bits(input int nbits);
        int value;
        value = 0;
        for (int i = 0; i < nbits; i++) begin
            value  = (value << 1) | int'(lfsr_q[0]);
            lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 16'hB400) : (lfsr_q >> 1);
        end
        return value;
    endfunction

    task automatic set_cmd(input int c, input int tile, input int vs, input int nb,
                           input int en, input int start, input logic right, input logic bcast);
        tile_q[c]  = disp_pkg::tile_addr_t'(tile);
        vs_q[c]    = disp_pkg::batch_cnt_t'(vs);
        nv_q[c]    = disp_pkg::batch_cnt_t'(vs * nb);
        en_q[c]    = disp_pkg::col_mask_t'(en);
        start_q[c] = disp_pkg::col_idx_t'(start);
        right_q[c] = right;
        bcast_q[c] = bcast;
    endtask

    // ==============================
    // Write monitor and compare
    // ==============================
    always @(posedge i_clk) begin : compare_writes
        disp_pkg::src_addr_t    exp_src;
        disp_pkg::tile_addr_t   exp_dst;
        disp_pkg::col_mask_t    exp_mask;
        logic                   side;
        if (i_reset_n) begin
            side = right_q[cur_cmd];
            if (o_tile_left_wr_en || o_tile_right_wr_en) begin
                if (wr_cnt >= exp_lines) begin
                    abort_run("tile write seen beyond the lines of the command");
                end else begin
                    ref_line(wr_cnt, exp_src, exp_dst, exp_mask);
                    check_eq("o_tile_left_wr_en", 32'(o_tile_left_wr_en), 32'(!side));
                    check_eq("o_tile_right_wr_en", 32'(o_tile_right_wr_en), 32'(side));
                    check_eq("o_src_left_rd_en", 32'(o_src_left_rd_en), 32'(!side));
                    check_eq("o_src_right_rd_en", 32'(o_src_right_rd_en), 32'(side));
                    check_eq("o_src_left_rd_addr", 32'(o_src_left_rd_addr),
                             side ? 32'd0 : 32'(exp_src));
                    check_eq("o_src_right_rd_addr", 32'(o_src_right_rd_addr),
                             side ? 32'(exp_src) : 32'd0);
                    check_eq("o_tile_wr_addr", 32'(o_tile_wr_addr), 32'(exp_dst));
                    check_eq("o_tile_col_wr_en", 32'(o_tile_col_wr_en), 32'(exp_mask));
                    check_eq("o_tile_man", o_tile_man, src_man(exp_src, side));
                    check_eq("o_tile_exp", 32'(o_tile_exp), 32'(src_exp(exp_src, side)));
                    wr_cnt = wr_cnt + 1;
                end
            end else begin
                // Quiet outside a copy
                check_eq("o_src_left_rd_en", 32'(o_src_left_rd_en), 32'd0);
                check_eq("o_src_right_rd_en", 32'(o_src_right_rd_en), 32'd0);
                check_eq("o_tile_col_wr_en", 32'(o_tile_col_wr_en), 32'd0);
            end
        end
    end

    always @(posedge i_clk) begin : watchdog
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt > cycle_limit) begin
            abort_run("timeout, the command sequence did not finish");
        end
    end

    // ==============================
    // Command driver
    // ==============================
    initial begin : drive
        int tile;
        int vs;
        int nb;
        int en;
        int start;
        int right;
        int bcast;
        int edges;
        i_reset_n       = 1'b0;
        i_cmd_req       = 1'b0;
        i_cmd_tile_addr = '0;
        i_cmd_nv_cnt    = '0;
        i_cmd_vec_size  = '0;
        i_cmd_col_en    = '0;
        i_cmd_col_start = '0;
        i_cmd_right     = 1'b0;
        i_cmd_broadcast = 1'b0;
        cur_cmd         = 0;
        exp_lines       = 0;
        wr_cnt          = 0;
        cycle_cnt       = 0;
        lfsr_q          = 16'd18344;
        // One column, sparse mask with wrap, broadcast, right side
        set_cmd(0, 'h010, 2, 3, 'h20, 0, 1'b0, 1'b0);
        set_cmd(1, 'h1F8, 1, 4, 'hA4, 5, 1'b0, 1'b0);
        set_cmd(2, 'h080, 3, 2, 'h5B, 6, 1'b0, 1'b1);
        set_cmd(3, 'h100, 4, 2, 'h81, 1, 1'b1, 1'b0);
        for (int c = num_dir; c < num_cmds; c++) begin
            tile  = draw_bits(9);
            vs    = draw_bits(2);
            nb    = draw_bits(2);
            en    = draw_bits(8);
            start = draw_bits(3);
            right = draw_bits(1);
            bcast = draw_bits(1);
            set_cmd(c, tile, vs + 1, nb + 1, (en == 0) ? 1 : en, start, right != 0, bcast != 0);
        end
        // L+8 cycles per command plus reset and margin
        cycle_limit = 60;
        for (int c = 0; c < num_cmds; c++) begin
            cycle_limit = cycle_limit + 4 * int'(nv_q[c]) + 8;
        end

        repeat (2) @(posedge i_clk);
        i_reset_n <= 1'b1;
        @(posedge i_clk);
        check_eq("o_cmd_ack", 32'(o_cmd_ack), 32'd0);
        check_eq("o_tile_left_wr_en", 32'(o_tile_left_wr_en), 32'd0);
        check_eq("o_tile_right_wr_en", 32'(o_tile_right_wr_en), 32'd0);

        for (int c = 0; c < num_cmds; c++) begin
            cur_cmd   = c;
            exp_lines = 4 * int'(nv_q[c]);
            wr_cnt    = 0;
            i_cmd_tile_addr <= tile_q[c];
            i_cmd_nv_cnt    <= nv_q[c];
            i_cmd_vec_size  <= vs_q[c];
            i_cmd_col_en    <= en_q[c];
            i_cmd_col_start <= start_q[c];
            i_cmd_right     <= right_q[c];
            i_cmd_broadcast <= bcast_q[c];
            i_cmd_req       <= 1'b1;
            // DUT samples req here
            @(posedge i_clk);
            edges = 0;
            while (o_cmd_ack !== 1'b1) begin
                @(posedge i_clk);
                edges = edges + 1;
            end
            check_eq("ack_latency", 32'(edges), 32'(exp_lines + 2));
            if (wr_cnt != exp_lines) begin
                abort_run($sformatf("command %0d wrote %0d lines, expected %0d",
                                    c, wr_cnt, exp_lines));
            end
            i_cmd_req <= 1'b0;
            @(posedge i_clk);
            // Ack holds until req is seen low
            check_eq("o_cmd_ack", 32'(o_cmd_ack), 32'd1);
            while (o_cmd_ack !== 1'b0) begin
                @(posedge i_clk);
            end
            @(posedge i_clk);
        end

        $display("TEST PASS");
        $finish;
    end

endmodule
